// File: tb.f
+incdir+source
+incdir+dv
source/fpu_data_pkg.sv
source/fpu_ctrl_pkg.sv
source/fpu_operand_fwd.sv
source/fpu_op_decode.sv
source/fpu_simd_execute.sv
source/fpu_excpt_retire.sv
source/fpu_cluster.sv
dv/fpu_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module fpu_cluster_tb \
  --Mdir obj_dir -o fpu_cluster_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/fpu_cluster_sim > sim.log 2>&1

grep -qx "Test passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: dv/fpu_tb_ref.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cluster reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_TB_REF_SVH
`define FPU_TB_REF_SVH

// expected lane result for a known opcode
function automatic fpu_word_t ref_result(input logic [`FPU_OP_W-1:0] op,
                                         input fpu_word_t a, input fpu_word_t b);
  fpu_word_t r;
  case (op)
    `FPU_OP_CPYA: r = a;
    `FPU_OP_CPYB: r = b;
    // singles of b change places
    `FPU_OP_SWPS: r = {b[`FPU_SINGLE_W-1:0], b[`FPU_WORD_W-1:`FPU_SINGLE_W]};
    `FPU_OP_DUPS: r = {b[`FPU_SINGLE_W-1:0], b[`FPU_SINGLE_W-1:0]};
    `FPU_OP_AND:  r = a & b;
    `FPU_OP_OR:   r = a | b;
    `FPU_OP_XOR:  r = a ^ b;
    `FPU_OP_ANDN: r = a & ~b;
    default:      r = '0;
  endcase
  return r;
endfunction

// masked raise bits, lowest enabled one wins
function automatic retire_t ref_retire(input fpu_tag_t tag, input excpt_bits_t raise,
                                       input excpt_bits_t enable);
  retire_t     r;
  excpt_bits_t hit;
  hit        = raise & enable;
  r.tag      = tag;
  r.exc_flag = 1'b0;
  r.exc_idx  = '0;
  for (int i = 0; i < `FPU_EXC_W; i++) begin
    if (hit[i] && !r.exc_flag) begin
      r.exc_flag = 1'b1;
      r.exc_idx  = 3'(i);
    end
  end
  return r;
endfunction

// only en with a known opcode produces a result
function automatic logic ref_valid(input fpu_issue_t iss);
  logic known;
  case (iss.op)
    `FPU_OP_CPYA, `FPU_OP_CPYB, `FPU_OP_SWPS, `FPU_OP_DUPS,
    `FPU_OP_AND, `FPU_OP_OR, `FPU_OP_XOR, `FPU_OP_ANDN: known = 1'b1;
    default: known = 1'b0;
  endcase
  return iss.en && known;
endfunction

`endif

// File: dv/fpu_cluster_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SIMD cluster testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_cluster_tb
  import fpu_data_pkg::*;
();

  localparam int N_IDLE  = 6;
  localparam int N_LOGIC = 40;
  localparam int N_PERM  = 24;
  localparam int N_FWD   = 24;
  localparam int N_XLANE = 16;
  localparam int N_EXC   = 40;
  localparam int MAX_CYCLES = 2 * (N_IDLE + N_LOGIC + N_PERM + N_FWD + N_XLANE + N_EXC) + 50;

  typedef logic [`FPU_OP_W-1:0] op_bits_t;

  typedef struct packed {
    fpu_word_t res;
    retire_t   ret;
    int        cyc;
  } exp_t;

  logic clk;
  logic rst;
  excpt_bits_t excpt_enable;
  fpu_word_t [`FPU_EXT_SLOTS-1:0] ext_bus;
  fpu_issue_t issue_in [2];
  fpu_word_t  a_rf [2];
  fpu_word_t  b_rf [2];
  fwd_sel_t   a_now [2];
  fwd_sel_t   a_prev [2];
  fwd_sel_t   b_now [2];
  fwd_sel_t   b_prev [2];
  fpu_word_t  res_out [2];
  logic       res_en [2];
  retire_t    ret_out [2];
  logic       ret_en [2];

  // next cycle's inputs, applied on the falling edge
  fpu_issue_t  stg_issue [2];
  fpu_word_t   stg_a [2];
  fpu_word_t   stg_b [2];
  fwd_sel_t    stg_an [2];
  fwd_sel_t    stg_ap [2];
  fwd_sel_t    stg_bn [2];
  fwd_sel_t    stg_bp [2];
  fpu_word_t [`FPU_EXT_SLOTS-1:0] stg_ext;
  excpt_bits_t stg_enable;

  // model of the result registers and bus history
  fpu_word_t mdl_res [2];
  fpu_bus_t  mdl_prev;
  logic      st0_v [2];
  logic      st1_v [2];
  fpu_word_t st0_r [2];
  fpu_word_t st1_r [2];
  exp_t      exp_q [2][$];
  int        cyc = 0;
  int        value_errs = 0;
  int        strobe_errs = 0;

  logic [`FPU_OP_W-1:0] perm_ops [4] = '{`FPU_OP_CPYA, `FPU_OP_CPYB, `FPU_OP_SWPS, `FPU_OP_DUPS};
  logic [`FPU_OP_W-1:0] logic_ops [4] = '{`FPU_OP_AND, `FPU_OP_OR, `FPU_OP_XOR, `FPU_OP_ANDN};

  `include "fpu_tb_ref.svh"

  fpu_cluster i_dut (
    .clk(clk), .rst(rst), .excpt_enable(excpt_enable), .ext_bus(ext_bus),
    .u1_issue(issue_in[0]), .u1_a_rf(a_rf[0]), .u1_b_rf(b_rf[0]),
    .u1_fwd_a_now(a_now[0]), .u1_fwd_a_prev(a_prev[0]),
    .u1_fwd_b_now(b_now[0]), .u1_fwd_b_prev(b_prev[0]),
    .u1_res(res_out[0]), .u1_res_en(res_en[0]), .u1_ret(ret_out[0]), .u1_ret_en(ret_en[0]),
    .u2_issue(issue_in[1]), .u2_a_rf(a_rf[1]), .u2_b_rf(b_rf[1]),
    .u2_fwd_a_now(a_now[1]), .u2_fwd_a_prev(a_prev[1]),
    .u2_fwd_b_now(b_now[1]), .u2_fwd_b_prev(b_prev[1]),
    .u2_res(res_out[1]), .u2_res_en(res_en[1]), .u2_ret(ret_out[1]), .u2_ret_en(ret_en[1])
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic fpu_word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic fpu_bus_t live_bus();
    fpu_bus_t b;
    b[0] = ext_bus[0];
    b[1] = ext_bus[1];
    b[2] = mdl_res[0];
    b[3] = mdl_res[1];
    return b;
  endfunction

  // live select beats registered select, rf otherwise
  function automatic fpu_word_t fwd_operand(input fpu_word_t rf, input fwd_sel_t now_sel,
                                            input fwd_sel_t prev_sel, input fpu_bus_t live,
                                            input fpu_bus_t prev);
    fpu_word_t v;
    v = rf;
    for (int s = 0; s < `FPU_NUM_SLOTS; s++) begin
      if (prev_sel[s]) begin
        v = prev[s];
      end
    end
    for (int s = 0; s < `FPU_NUM_SLOTS; s++) begin
      if (now_sel[s]) begin
        v = live[s];
      end
    end
    return v;
  endfunction

  task automatic clear_stage(input int l);
    stg_issue[l] = '0;
    stg_an[l]    = '0;
    stg_ap[l]    = '0;
    stg_bn[l]    = '0;
    stg_bp[l]    = '0;
  endtask

  task automatic stage_op(input int l, input logic [`FPU_OP_W-1:0] op, input excpt_bits_t raise,
                          input fwd_sel_t an, input fwd_sel_t ap,
                          input fwd_sel_t bn, input fwd_sel_t bp);
    stg_issue[l].en    = 1'b1;
    stg_issue[l].op    = op;
    stg_issue[l].tag   = fpu_tag_t'($urandom);
    stg_issue[l].raise = raise;
    stg_a[l]  = rand_word();
    stg_b[l]  = rand_word();
    stg_an[l] = an;
    stg_ap[l] = ap;
    stg_bn[l] = bn;
    stg_bp[l] = bp;
  endtask

  // one-hot select on the live or the registered bus, at random
  task automatic pick_fwd(input int slot, output fwd_sel_t now_sel, output fwd_sel_t prev_sel);
    now_sel  = '0;
    prev_sel = '0;
    if ($urandom % 2) begin
      prev_sel = fwd_sel_t'(1 << slot);
    end else begin
      now_sel = fwd_sel_t'(1 << slot);
    end
  endtask

  // drive staged inputs and push expected results
  task automatic apply_cycle();
    fpu_bus_t  lb;
    fpu_word_t oa;
    fpu_word_t ob;
    exp_t      e;
    @(negedge clk);
    ext_bus      = stg_ext;
    excpt_enable = stg_enable;
    lb = live_bus();
    for (int l = 0; l < 2; l++) begin
      issue_in[l] = stg_issue[l];
      a_rf[l]     = stg_a[l];
      b_rf[l]     = stg_b[l];
      a_now[l]    = stg_an[l];
      a_prev[l]   = stg_ap[l];
      b_now[l]    = stg_bn[l];
      b_prev[l]   = stg_bp[l];
      oa = fwd_operand(stg_a[l], stg_an[l], stg_ap[l], lb, mdl_prev);
      ob = fwd_operand(stg_b[l], stg_bn[l], stg_bp[l], lb, mdl_prev);
      st0_v[l] = ref_valid(stg_issue[l]);
      st0_r[l] = ref_result(stg_issue[l].op, oa, ob);
      if (st0_v[l]) begin
        e.res = st0_r[l];
        e.ret = ref_retire(stg_issue[l].tag, stg_issue[l].raise, stg_enable);
        e.cyc = cyc + 2;
        exp_q[l].push_back(e);
      end
      clear_stage(l);
    end
  endtask

  task automatic drain();
    while (exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
      apply_cycle();
    end
    repeat (2) apply_cycle();
  endtask

  // model pipeline, cycle count and timeout
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cyc);
      $display("Test failed");
      $finish;
    end
    mdl_prev = live_bus();
    for (int l = 0; l < 2; l++) begin
      if (rst) begin
        mdl_res[l] = '0;
        st1_v[l]   = 1'b0;
      end else begin
        if (st1_v[l]) begin
          mdl_res[l] = st1_r[l];
        end
        st1_v[l] = st0_v[l];
        st1_r[l] = st0_r[l];
      end
      st0_v[l] = 1'b0;
    end
  end

  task automatic check_lane(input int l);
    exp_t e;
    logic late;
    if (res_en[l] || ret_en[l]) begin
      assert (exp_q[l].size() > 0) else begin
        $display("CHECK FAILED at %0t: lane %0d strobe with no op pending", $time, l + 1);
        strobe_errs++;
      end
      if (exp_q[l].size() > 0) begin
        e = exp_q[l].pop_front();
        assert (res_en[l] && ret_en[l]) else begin
          $display("CHECK FAILED at %0t: lane %0d res_en %0b and ret_en %0b differ",
                   $time, l + 1, res_en[l], ret_en[l]);
          strobe_errs++;
        end
        assert (cyc == e.cyc) else begin
          $display("CHECK FAILED at %0t: lane %0d strobe in cycle %0d, expected %0d",
                   $time, l + 1, cyc, e.cyc);
          strobe_errs++;
        end
        assert (res_out[l] == e.res) else begin
          $display("CHECK FAILED at %0t: lane %0d result %h, expected %h",
                   $time, l + 1, res_out[l], e.res);
          value_errs++;
        end
        assert (ret_out[l] == e.ret) else begin
          $display("CHECK FAILED at %0t: lane %0d retire %h, expected %h",
                   $time, l + 1, ret_out[l], e.ret);
          value_errs++;
        end
      end
    end else begin
      // result register holds between strobes
      assert (res_out[l] == mdl_res[l]) else begin
        $display("CHECK FAILED at %0t: lane %0d held result %h, expected %h",
                 $time, l + 1, res_out[l], mdl_res[l]);
        value_errs++;
      end
      late = exp_q[l].size() > 0 && exp_q[l][0].cyc < cyc;
      assert (!late) else begin
        $display("CHECK FAILED at %0t: lane %0d strobe missing in cycle %0d",
                 $time, l + 1, cyc - 1);
        strobe_errs++;
      end
      if (late) begin
        e = exp_q[l].pop_front();
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      for (int l = 0; l < 2; l++) begin
        check_lane(l);
      end
    end
  end

  initial begin
    fwd_sel_t an;
    fwd_sel_t ap;
    void'($urandom(51184));
    rst          = 1'b1;
    excpt_enable = '0;
    ext_bus      = '0;
    stg_ext      = '0;
    stg_enable   = '1;
    for (int l = 0; l < 2; l++) begin
      issue_in[l] = '0;
      a_rf[l]     = '0;
      b_rf[l]     = '0;
      a_now[l]    = '0;
      a_prev[l]   = '0;
      b_now[l]    = '0;
      b_prev[l]   = '0;
      stg_a[l]    = '0;
      stg_b[l]    = '0;
      clear_stage(l);
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // idle after reset, en low with random opcodes
    for (int n = 0; n < N_IDLE; n++) begin
      for (int l = 0; l < 2; l++) begin
        stg_issue[l].op  = op_bits_t'($urandom);
        stg_issue[l].tag = fpu_tag_t'($urandom);
        stg_a[l] = rand_word();
        stg_b[l] = rand_word();
      end
      apply_cycle();
    end

    // logic ops on rf operands, every cycle
    for (int n = 0; n < N_LOGIC; n++) begin
      for (int l = 0; l < 2; l++) begin
        stage_op(l, logic_ops[$urandom % 4], '0, '0, '0, '0, '0);
      end
      apply_cycle();
    end
    drain();

    for (int n = 0; n < N_PERM; n++) begin
      for (int l = 0; l < 2; l++) begin
        stage_op(l, perm_ops[n % 4], '0, '0, '0, '0, '0);
      end
      apply_cycle();
    end
    drain();

    // operands from the external slots, live and registered
    for (int n = 0; n < N_FWD; n++) begin
      stg_ext = {rand_word(), rand_word()};
      for (int l = 0; l < 2; l++) begin
        stage_op(l, perm_ops[$urandom % 4], '0, '0, '0, '0, '0);
        pick_fwd($urandom % 2, stg_an[l], stg_ap[l]);
        pick_fwd($urandom % 2, stg_bn[l], stg_bp[l]);
      end
      apply_cycle();
    end
    drain();

    // lane 2 reads lane 1's slot
    for (int n = 0; n < N_XLANE; n++) begin
      stage_op(0, logic_ops[$urandom % 4], '0, '0, '0, '0, '0);
      pick_fwd(2, an, ap);
      stage_op(1, ($urandom % 2) ? perm_ops[0] : logic_ops[$urandom % 4], '0, an, ap, '0, '0);
      apply_cycle();
    end
    drain();

    // random opcodes incl nop and unknown, random raise and enable
    for (int n = 0; n < N_EXC; n++) begin
      stg_enable = excpt_bits_t'($urandom);
      for (int l = 0; l < 2; l++) begin
        stage_op(l, op_bits_t'($urandom), excpt_bits_t'($urandom), '0, '0, '0, '0);
      end
      apply_cycle();
    end
    drain();

    $display("checks done: %0d value errors, %0d strobe errors", value_errs, strobe_errs);
    if (value_errs + strobe_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/fpu_cluster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-lane SIMD permute cluster
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_cluster
  import fpu_data_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  excpt_bits_t                    excpt_enable,
  input  fpu_word_t [`FPU_EXT_SLOTS-1:0] ext_bus,
  // lane 1
  input  fpu_issue_t u1_issue,
  input  fpu_word_t  u1_a_rf,
  input  fpu_word_t  u1_b_rf,
  input  fwd_sel_t   u1_fwd_a_now,
  input  fwd_sel_t   u1_fwd_a_prev,
  input  fwd_sel_t   u1_fwd_b_now,
  input  fwd_sel_t   u1_fwd_b_prev,
  output fpu_word_t  u1_res,
  output logic       u1_res_en,
  output retire_t    u1_ret,
  output logic       u1_ret_en,
  // lane 2
  input  fpu_issue_t u2_issue,
  input  fpu_word_t  u2_a_rf,
  input  fpu_word_t  u2_b_rf,
  input  fwd_sel_t   u2_fwd_a_now,
  input  fwd_sel_t   u2_fwd_a_prev,
  input  fwd_sel_t   u2_fwd_b_now,
  input  fwd_sel_t   u2_fwd_b_prev,
  output fpu_word_t  u2_res,
  output logic       u2_res_en,
  output retire_t    u2_ret,
  output logic       u2_ret_en
);

  fpu_bus_t   bus;
  fpu_bus_t   bus_prev;
  fpu_issue_t issue [2];
  fpu_word_t  a_rf [2];
  fpu_word_t  b_rf [2];
  fwd_sel_t   fwd_a_now [2];
  fwd_sel_t   fwd_a_prev [2];
  fwd_sel_t   fwd_b_now [2];
  fwd_sel_t   fwd_b_prev [2];
  fpu_word_t  op_a [2];
  fpu_word_t  op_b [2];
  fpu_ctrl_t  ctrl [2];
  fpu_word_t  a_q [2];
  fpu_word_t  b_q [2];
  fpu_tag_t   tag_q [2];
  excpt_bits_t exc_q [2];
  fpu_word_t  res [2];
  logic       res_en [2];
  retire_t    ret [2];
  logic       ret_en [2];

  // lane port arrays
  assign issue      = '{u1_issue, u2_issue};
  assign a_rf       = '{u1_a_rf, u2_a_rf};
  assign b_rf       = '{u1_b_rf, u2_b_rf};
  assign fwd_a_now  = '{u1_fwd_a_now, u2_fwd_a_now};
  assign fwd_a_prev = '{u1_fwd_a_prev, u2_fwd_a_prev};
  assign fwd_b_now  = '{u1_fwd_b_now, u2_fwd_b_now};
  assign fwd_b_prev = '{u1_fwd_b_prev, u2_fwd_b_prev};
  assign u1_res     = res[0];
  assign u2_res     = res[1];
  assign u1_res_en  = res_en[0];
  assign u2_res_en  = res_en[1];
  assign u1_ret     = ret[0];
  assign u2_ret     = ret[1];
  assign u1_ret_en  = ret_en[0];
  assign u2_ret_en  = ret_en[1];

  // low slots come from outside
  for (genvar e = 0; e < `FPU_EXT_SLOTS; e++) begin : g_ext
    assign bus[e] = ext_bus[e];
  end

  always_ff @(posedge clk) begin
    bus_prev <= bus;
  end

  for (genvar g = 0; g < 2; g++) begin : g_lane
    // lane g owns slot ext + g
    assign bus[`FPU_EXT_SLOTS + g] = res[g];

    fpu_operand_fwd i_fwd_a (
      .rf_data(a_rf[g]), .fwd_now(fwd_a_now[g]), .fwd_prev(fwd_a_prev[g]),
      .bus(bus), .bus_prev(bus_prev), .operand(op_a[g])
    );

    fpu_operand_fwd i_fwd_b (
      .rf_data(b_rf[g]), .fwd_now(fwd_b_now[g]), .fwd_prev(fwd_b_prev[g]),
      .bus(bus), .bus_prev(bus_prev), .operand(op_b[g])
    );

    fpu_op_decode i_decode (
      .clk(clk), .rst(rst), .issue(issue[g]), .excpt_enable(excpt_enable),
      .op_a(op_a[g]), .op_b(op_b[g]), .ctrl(ctrl[g]), .a_q(a_q[g]),
      .b_q(b_q[g]), .tag_q(tag_q[g]), .exc_q(exc_q[g])
    );

    fpu_simd_execute i_execute (
      .clk(clk), .rst(rst), .ctrl(ctrl[g]), .a(a_q[g]), .b(b_q[g]),
      .res(res[g]), .res_en(res_en[g])
    );

    fpu_excpt_retire i_retire (
      .clk(clk), .rst(rst), .valid(ctrl[g].valid), .tag(tag_q[g]),
      .exc(exc_q[g]), .ret(ret[g]), .ret_en(ret_en[g])
    );

    // at most one source per operand, live or registered
    a_fwd_onehot: assert property (
      @(posedge clk) disable iff (rst)
      issue[g].en |-> $onehot0({fwd_a_now[g], fwd_a_prev[g]})
                   && $onehot0({fwd_b_now[g], fwd_b_prev[g]})
    ) else $error("lane %0d forwarding selects not one-hot", g + 1);
  end

endmodule

`default_nettype wire

// File: source/fpu_excpt_retire.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exception pick and retire
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_excpt_retire
  import fpu_data_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid,
  input  fpu_tag_t    tag,
  input  excpt_bits_t exc,
  output retire_t     ret,
  output logic        ret_en
);

  excpt_idx_t idx;
  retire_t    ret_d;

  // scan from the top so the lowest set bit is the last write
  always_comb begin
    idx = '0;
    for (int i = `FPU_EXC_W - 1; i >= 0; i--) begin
      if (exc[i]) begin
        idx = excpt_idx_t'(i);
      end
    end
  end

  assign ret_d.tag      = tag;
  assign ret_d.exc_flag = |exc;
  assign ret_d.exc_idx  = idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_en <= 1'b0;
    end else begin
      ret_en <= valid;
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      ret <= ret_d;
    end
  end

  a_flag_needs_raise: assert property (
    @(posedge clk) disable iff (rst)
    ret_en && ret.exc_flag |-> $past(valid && (exc != '0))
  ) else $error("retire flag without an enabled raise bit");

endmodule

`default_nettype wire

// File: source/fpu_simd_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Permute and logic datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_simd_execute
  import fpu_data_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fpu_ctrl_t ctrl,
  input  fpu_word_t a,
  input  fpu_word_t b,
  output fpu_word_t res,
  output logic      res_en
);

  fpu_single_t b_lo;
  fpu_single_t b_hi;
  fpu_word_t   perm_res;
  fpu_word_t   logic_res;
  fpu_word_t   res_d;

  assign b_lo = b[`FPU_SINGLE_W-1:0];
  assign b_hi = b[`FPU_WORD_W-1:`FPU_SINGLE_W];

  // packed single permutes
  always_comb begin
    case (ctrl.perm_kind)
      PERM_CPYA: perm_res = a;
      PERM_CPYB: perm_res = b;
      PERM_SWAP: perm_res = {b_lo, b_hi};
      default:   perm_res = {b_lo, b_lo};
    endcase
  end

  always_comb begin
    case (ctrl.logic_sel)
      LSEL_AND: logic_res = a & b;
      LSEL_OR:  logic_res = a | b;
      LSEL_XOR: logic_res = a ^ b;
      default:  logic_res = a & ~b;
    endcase
  end

  assign res_d = ctrl.is_logic ? logic_res : perm_res;

  // result holds until the next valid op
  always_ff @(posedge clk) begin
    if (rst) begin
      res    <= '0;
      res_en <= 1'b0;
    end else begin
      res_en <= ctrl.valid;
      if (ctrl.valid) begin
        res <= res_d;
      end
    end
  end

  // back-to-back strobes need back-to-back valids
  a_res_en_from_valid: assert property (
    @(posedge clk) disable iff (rst)
    res_en && $past(res_en) |-> $past(ctrl.valid)
  ) else $error("res_en without a decoded valid");

endmodule

`default_nettype wire

// File: source/fpu_op_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane opcode decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fpu_op_decode
  import fpu_data_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fpu_issue_t  issue,
  input  excpt_bits_t excpt_enable,
  input  fpu_word_t   op_a,
  input  fpu_word_t   op_b,
  output fpu_ctrl_t   ctrl,
  output fpu_word_t   a_q,
  output fpu_word_t   b_q,
  output fpu_tag_t    tag_q,
  output excpt_bits_t exc_q
);

  fpu_op_e   op;
  fpu_ctrl_t ctrl_d;
  logic      known;

  assign op = fpu_op_e'(issue.op);

  always_comb begin
    ctrl_d = '0;
    known  = 1'b1;
    case (op)
      OP_CPYA: ctrl_d.perm_kind = PERM_CPYA;
      OP_CPYB: ctrl_d.perm_kind = PERM_CPYB;
      OP_SWPS: ctrl_d.perm_kind = PERM_SWAP;
      OP_DUPS: ctrl_d.perm_kind = PERM_DUP;
      OP_AND, OP_OR, OP_XOR, OP_ANDN: begin
        ctrl_d.is_logic  = 1'b1;
        // logic opcodes carry the select in bits 1:0
        ctrl_d.logic_sel = logic_sel_e'(issue.op[1:0]);
      end
      default: known = 1'b0;
    endcase
    // nop lands here too
    ctrl_d.valid = issue.en & known;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    a_q   <= op_a;
    b_q   <= op_b;
    tag_q <= issue.tag;
    exc_q <= issue.raise & excpt_enable;
  end

  a_no_valid_without_en: assert property (
    @(posedge clk) disable iff (rst) !issue.en |=> !ctrl.valid
  ) else $error("decode valid after an issue with en low");

endmodule

`default_nettype wire

// File: source/fpu_operand_fwd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand bypass mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_operand_fwd
  import fpu_data_pkg::*;
(
  input  fpu_word_t rf_data,
  input  fwd_sel_t  fwd_now,
  input  fwd_sel_t  fwd_prev,
  input  fpu_bus_t  bus,
  input  fpu_bus_t  bus_prev,
  output fpu_word_t operand
);

  fpu_word_t now_val;
  fpu_word_t prev_val;
  logic      hit_now;
  logic      hit_prev;

  assign hit_now  = |fwd_now;
  assign hit_prev = |fwd_prev;

  // live bus slot
  always_comb begin
    now_val = '0;
    for (int i = 0; i < `FPU_NUM_SLOTS; i++) begin
      if (fwd_now[i]) begin
        now_val = bus[i];
      end
    end
  end

  // slot as seen one cycle back
  always_comb begin
    prev_val = '0;
    for (int i = 0; i < `FPU_NUM_SLOTS; i++) begin
      if (fwd_prev[i]) begin
        prev_val = bus_prev[i];
      end
    end
  end

  // live wins over registered, rf is the fallback
  always_comb begin
    if (hit_now) begin
      operand = now_val;
    end else if (hit_prev) begin
      operand = prev_val;
    end else begin
      operand = rf_data;
    end
  end

endmodule

`default_nettype wire

// File: source/fpu_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SIMD cluster control types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "fpu_consts.svh"

package fpu_ctrl_pkg;

  typedef enum logic [`FPU_OP_W-1:0] {
    OP_NOP  = `FPU_OP_NOP,
    OP_CPYA = `FPU_OP_CPYA,
    OP_CPYB = `FPU_OP_CPYB,
    OP_SWPS = `FPU_OP_SWPS,
    OP_DUPS = `FPU_OP_DUPS,
    OP_AND  = `FPU_OP_AND,
    OP_OR   = `FPU_OP_OR,
    OP_XOR  = `FPU_OP_XOR,
    OP_ANDN = `FPU_OP_ANDN
  } fpu_op_e;

  typedef enum logic [1:0] {
    LSEL_AND  = 2'd0,
    LSEL_OR   = 2'd1,
    LSEL_XOR  = 2'd2,
    LSEL_ANDN = 2'd3
  } logic_sel_e;

  typedef enum logic [1:0] {
    PERM_CPYA = 2'd0,
    PERM_CPYB = 2'd1,
    PERM_SWAP = 2'd2,
    PERM_DUP  = 2'd3
  } perm_kind_e;

  typedef struct packed {
    logic       valid;
    logic       is_logic;
    logic_sel_e logic_sel;
    perm_kind_e perm_kind;
  } fpu_ctrl_t;

endpackage

`default_nettype wire

// File: source/fpu_data_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SIMD cluster data types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "fpu_consts.svh"

package fpu_data_pkg;

  typedef logic [`FPU_WORD_W-1:0]   fpu_word_t;
  typedef logic [`FPU_SINGLE_W-1:0] fpu_single_t;
  typedef fpu_word_t [`FPU_NUM_SLOTS-1:0] fpu_bus_t;
  typedef logic [`FPU_NUM_SLOTS-1:0] fwd_sel_t;
  typedef logic [`FPU_EXC_W-1:0]    excpt_bits_t;
  typedef logic [`FPU_TAG_W-1:0]    fpu_tag_t;
  typedef logic [2:0]               excpt_idx_t;

  // retire code, 13 bits
  typedef struct packed {
    fpu_tag_t   tag;
    logic       exc_flag;
    excpt_idx_t exc_idx;
  } retire_t;

  typedef struct packed {
    logic                 en;
    logic [`FPU_OP_W-1:0] op;
    fpu_tag_t             tag;
    excpt_bits_t          raise;
  } fpu_issue_t;

endpackage

`default_nettype wire

// File: source/fpu_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SIMD cluster constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// datapath widths
`define FPU_WORD_W     64
`define FPU_SINGLE_W   32
`define FPU_NUM_SLOTS  4
`define FPU_EXT_SLOTS  2
`define FPU_OP_W       4
`define FPU_EXC_W      5
`define FPU_TAG_W      9

// opcodes, logic ops keep the select in the low two bits
`define FPU_OP_NOP     4'h0
`define FPU_OP_CPYA    4'h1
`define FPU_OP_CPYB    4'h2
`define FPU_OP_SWPS    4'h3
`define FPU_OP_DUPS    4'h4
`define FPU_OP_AND     4'h8
`define FPU_OP_OR      4'h9
`define FPU_OP_XOR     4'ha
`define FPU_OP_ANDN    4'hb

`endif
